// ==== bubsys.f ====
hw/bubsys_pkg.sv
hw/bubsys_addr_decode.sv
hw/bubsys_work_ram.sv
hw/bubsys_dtack_gen.sv
hw/bubsys_irq_ctrl.sv
hw/bubsys_cfg_latch.sv
hw/bubsys_palette.sv
hw/bubsys_main_bus.sv
tb/tb_bubsys.sv

// ==== hw/bubsys_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubsys_addr_decode
    import bubsys_pkg::*;
(
    input  cpu_addr_t i_addr,
    input  logic      i_as_n,
    output logic      o_workram_cs,
    output logic      o_palram_cs,
    output logic      o_syscfg_cs,
    output logic      o_sndlatch_cs,
    output logic      o_btn_cs,
    output logic      o_dip_cs,
    output logic      o_sndram_cs,
    output logic      o_vzcs_n,
    output logic      o_vcs1_n,
    output logic      o_vcs2_n,
    output logic      o_chacs_n,
    output logic      o_objram_n
);

    logic dec_en;

    // game rom (a19) and the vpa space (a23) stay out
    assign dec_en = ~i_as_n & ~i_addr[23] & ~i_addr[19];

    always_comb begin
        o_workram_cs  = 1'b0;
        o_palram_cs   = 1'b0;
        o_syscfg_cs   = 1'b0;
        o_sndlatch_cs = 1'b0;
        o_btn_cs      = 1'b0;
        o_dip_cs      = 1'b0;
        o_sndram_cs   = 1'b0;
        o_vzcs_n      = 1'b1;
        o_vcs1_n      = 1'b1;
        o_vcs2_n      = 1'b1;
        o_chacs_n     = 1'b1;
        o_objram_n    = 1'b1;

        if (dec_en) begin
            case (i_addr[18:16])
                PAGE_WORK:   o_workram_cs = 1'b1;
                PAGE_SNDRAM: o_sndram_cs  = 1'b1;
                PAGE_CHAR:   o_chacs_n    = 1'b0;
                PAGE_VIDEO: begin
                    case (i_addr[15:13])
                        SUB_VZ:  o_vzcs_n    = 1'b0;
                        SUB_V1:  o_vcs1_n    = 1'b0;
                        SUB_V2:  o_vcs2_n    = 1'b0;
                        SUB_OBJ: o_objram_n  = 1'b0;
                        SUB_PAL: o_palram_cs = 1'b1;
                        SUB_CFG: o_syscfg_cs = 1'b1;
                        SUB_SYS: begin
                            o_sndlatch_cs = (i_addr[12:10] == IO_SNDLATCH);
                            o_dip_cs      = (i_addr[12:10] == IO_DIP);
                            o_btn_cs      = (i_addr[12:10] == IO_BTN);
                        end
                        default: ;
                    endcase
                end
                PAGE_BOOT, PAGE_EXT: ;  // rom and expansion ram live off board
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/bubsys_cfg_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubsys_cfg_latch
    import bubsys_pkg::*;
(
    input  logic      mclk,
    input  logic      maincpu_rst,
    input  logic      i_syscfg_cs,
    input  logic      i_sndlatch_cs,
    input  cpu_addr_t i_addr,
    input  cpu_data_t i_data,
    input  logic      i_r_nw,
    input  logic      i_uds_n,
    input  logic      i_lds_n,
    output logic      o_snd_int,
    output logic      o_snd_nmi,
    output logic      o_ack_timer_n,
    output logic      o_ack_vblank_n,
    output logic      o_ack_fparity_n,
    output logic      o_hflip,
    output logic      o_vflip,
    output byte_t     o_snd_code
);

    logic cfg_wr;

    assign cfg_wr = i_syscfg_cs & ~i_r_nw;

    // addressable bit latch, one bit per word offset
    always_ff @(posedge mclk) begin
        if (maincpu_rst) begin
            o_snd_int       <= 1'b0;
            o_snd_nmi       <= 1'b0;
            o_ack_timer_n   <= 1'b0;
            o_ack_vblank_n  <= 1'b0;
            o_ack_fparity_n <= 1'b0;
            o_hflip         <= 1'b0;
            o_vflip         <= 1'b0;
        end else if (cfg_wr) begin
            if (!i_uds_n) begin
                case (i_addr[3:1])
                    3'd2:    o_snd_int     <= i_data[8];
                    3'd4:    o_snd_nmi     <= i_data[8];
                    3'd7:    o_ack_timer_n <= i_data[8];
                    default: ;  // coin counters, bus request not fitted
                endcase
            end
            if (!i_lds_n) begin
                case (i_addr[3:1])
                    3'd0:    o_ack_vblank_n  <= i_data[0];
                    3'd1:    o_ack_fparity_n <= i_data[0];
                    3'd2:    o_hflip         <= i_data[0];
                    3'd3:    o_vflip         <= i_data[0];
                    default: ;
                endcase
            end
        end
    end

    // sound code, low byte lane only
    always_ff @(posedge mclk) begin
        if (maincpu_rst) begin
            o_snd_code <= 8'h00;
        end else if (i_sndlatch_cs && !i_r_nw && !i_lds_n) begin
            o_snd_code <= i_data[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/bubsys_dtack_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubsys_dtack_gen (
    input  logic mclk,
    input  logic maincpu_rst,
    input  logic i_clk6m_pcen,
    input  logic i_clk6m_ncen,
    input  logic i_abs_1h_n,
    input  logic i_abs_2h,
    input  logic i_uds_n,
    input  logic i_lds_n,
    input  logic i_workram_cs,
    input  logic i_sndram_cs,
    input  logic i_chacs_n,
    input  logic i_vcs1_n,
    input  logic i_vcs2_n,
    input  logic i_vzcs_n,
    input  logic i_objram_n,
    input  logic i_wram_ready,
    output logic o_dtack_n
);

    logic       ds_idle;
    logic       dtack1_n, dtack2_pre_n, dtack2_n;
    logic [1:0] dtack_sel;
    logic       dtack_mux_n;

    assign ds_idle = i_uds_n & i_lds_n;

    // video slot wait flops
    always_ff @(posedge mclk) begin
        if (maincpu_rst || ds_idle) begin
            dtack1_n     <= 1'b1;
            dtack2_pre_n <= 1'b1;
            dtack2_n     <= 1'b1;
        end else begin
            if (i_clk6m_pcen) begin
                if (!i_abs_1h_n) dtack1_n <= 1'b0;
                dtack2_pre_n <= 1'b0;               // one 6M step seen
            end
            if (i_clk6m_ncen && !i_abs_2h && i_abs_1h_n) begin
                dtack2_n <= dtack2_pre_n;           // 2H = 1H = 0 slot
            end
        end
    end

    assign dtack_sel[1] = i_workram_cs | i_sndram_cs | ~i_chacs_n | ~i_vcs1_n | ~i_vcs2_n;
    assign dtack_sel[0] = i_workram_cs | ~i_vzcs_n | ~i_objram_n;

    always_comb begin
        case (dtack_sel)
            2'd0:    dtack_mux_n = 1'b0;            // rom and io, no wait
            2'd1:    dtack_mux_n = dtack1_n;        // scroll ram, obj ram
            2'd2:    dtack_mux_n = dtack2_n;        // snd, char, vram 1/2
            default: dtack_mux_n = ~i_wram_ready;
        endcase
    end

    assign o_dtack_n = ds_idle | dtack_mux_n;

endmodule

`default_nettype wire

// ==== hw/bubsys_irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubsys_irq_ctrl
    import bubsys_pkg::*;
(
    input  logic mclk,
    input  logic maincpu_rst,
    input  logic i_clk9m_pcen,
    input  logic i_vblank_n,
    input  logic i_frame_parity,
    input  logic i_ack_vblank_n,
    input  logic i_ack_fparity_n,
    input  logic i_ack_timer_n,
    output ipl_t o_ipl_n
);

    logic [2:0] vbl_sync;   // two sync stages plus edge delay
    logic [2:0] par_sync;
    logic       vbl_rise, par_rise;
    logic [2:0] ack_n;      // {timer, vblank, fparity}
    logic [2:0] rise;
    logic [2:0] pend;

    assign vbl_rise = vbl_sync[1] & ~vbl_sync[2];
    assign par_rise = par_sync[1] & ~par_sync[2];

    // vblank start drives both timer and vblank sources
    assign ack_n = {i_ack_timer_n, i_ack_vblank_n, i_ack_fparity_n};
    assign rise  = {vbl_rise, vbl_rise, par_rise};

    always_ff @(posedge mclk) begin
        if (maincpu_rst) begin
            vbl_sync <= 3'b000;
            par_sync <= 3'b000;
            pend     <= 3'b000;
            o_ipl_n  <= IPL_NONE;
        end else begin
            vbl_sync <= {vbl_sync[1:0], ~i_vblank_n};
            par_sync <= {par_sync[1:0], i_frame_parity};

            for (int i = 0; i < 3; i++) begin
                if (!ack_n[i]) pend[i] <= 1'b0;    // held clear during ack
                else if (rise[i]) pend[i] <= 1'b1;
            end

            ////////////////////////////////////////////////////////////
            // priority encoder, timer > vblank > frame parity
            if (i_clk9m_pcen) begin
                if (pend[2]) o_ipl_n <= IPL_TIMER;
                else if (pend[1]) o_ipl_n <= IPL_VBLANK;
                else if (pend[0]) o_ipl_n <= IPL_FPARITY;
                else o_ipl_n <= IPL_NONE;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/bubsys_main_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubsys_main_bus
    import bubsys_pkg::*;
(
    input  logic        mclk,
    input  logic        maincpu_rst,
    input  logic        i_clk6m_pcen,
    input  logic        i_clk6m_ncen,
    input  logic        i_clk9m_pcen,
    input  logic        i_abs_1h_n,
    input  logic        i_abs_2h,
    input  logic        i_abs_32h,
    input  logic        i_vblank_n,
    input  logic        i_frame_parity,
    input  logic        i_blk,
    input  pal_addr_t   i_cd,
    // cpu bus
    input  cpu_addr_t   i_addr,
    input  logic        i_as_n,
    input  logic        i_uds_n,
    input  logic        i_lds_n,
    input  logic        i_r_nw,
    input  cpu_data_t   i_data,
    output cpu_data_t   o_data,
    output logic        o_dtack_n,
    output ipl_t        o_ipl_n,
    // graphics board
    input  cpu_data_t   i_gfx_do,
    output logic [14:0] o_gfx_addr,
    output cpu_data_t   o_gfx_di,
    output logic        o_gfx_r_nw,
    output logic        o_gfx_uds_n,
    output logic        o_gfx_lds_n,
    output logic        o_vzcs_n,
    output logic        o_vcs1_n,
    output logic        o_vcs2_n,
    output logic        o_chacs_n,
    output logic        o_objram_n,
    output logic        o_sndram_cs,
    output logic        o_hflip,
    output logic        o_vflip,
    // sound cpu
    output logic        o_snd_int,
    output logic        o_snd_nmi,
    output byte_t       o_snd_code,
    // panel and dips
    input  byte_t       i_in0,
    input  byte_t       i_in1,
    input  byte_t       i_in2,
    input  byte_t       i_dipsw1,
    input  byte_t       i_dipsw2,
    input  byte_t       i_dipsw3,
    output color_t      o_video_r,
    output color_t      o_video_g,
    output color_t      o_video_b
);

    logic      workram_cs, palram_cs, syscfg_cs, sndlatch_cs, btn_cs, dip_cs;
    logic      wram_ready, gfx_cs;
    logic      ack_vblank_n, ack_fparity_n, ack_timer_n;
    cpu_data_t workram_q, palram_q;

    assign o_gfx_addr  = i_addr[15:1];
    assign o_gfx_di    = i_data;
    assign o_gfx_r_nw  = i_r_nw;
    assign o_gfx_uds_n = i_uds_n;
    assign o_gfx_lds_n = i_lds_n;

    ////////////////////////////////////////////////////////////
    // bus glue blocks

    bubsys_addr_decode u_decode (
        .i_addr(i_addr), .i_as_n(i_as_n),
        .o_workram_cs(workram_cs), .o_palram_cs(palram_cs),
        .o_syscfg_cs(syscfg_cs), .o_sndlatch_cs(sndlatch_cs),
        .o_btn_cs(btn_cs), .o_dip_cs(dip_cs), .o_sndram_cs(o_sndram_cs),
        .o_vzcs_n(o_vzcs_n), .o_vcs1_n(o_vcs1_n), .o_vcs2_n(o_vcs2_n),
        .o_chacs_n(o_chacs_n), .o_objram_n(o_objram_n)
    );

    bubsys_work_ram u_work_ram (
        .mclk(mclk), .maincpu_rst(maincpu_rst),
        .i_clk6m_pcen(i_clk6m_pcen), .i_abs_32h(i_abs_32h),
        .i_workram_cs(workram_cs), .i_addr(i_addr), .i_data(i_data),
        .i_r_nw(i_r_nw), .i_uds_n(i_uds_n), .i_lds_n(i_lds_n),
        .o_q(workram_q), .o_wram_ready(wram_ready)
    );

    bubsys_dtack_gen u_dtack (
        .mclk(mclk), .maincpu_rst(maincpu_rst),
        .i_clk6m_pcen(i_clk6m_pcen), .i_clk6m_ncen(i_clk6m_ncen),
        .i_abs_1h_n(i_abs_1h_n), .i_abs_2h(i_abs_2h),
        .i_uds_n(i_uds_n), .i_lds_n(i_lds_n),
        .i_workram_cs(workram_cs), .i_sndram_cs(o_sndram_cs),
        .i_chacs_n(o_chacs_n), .i_vcs1_n(o_vcs1_n), .i_vcs2_n(o_vcs2_n),
        .i_vzcs_n(o_vzcs_n), .i_objram_n(o_objram_n),
        .i_wram_ready(wram_ready), .o_dtack_n(o_dtack_n)
    );

    bubsys_irq_ctrl u_irq (
        .mclk(mclk), .maincpu_rst(maincpu_rst), .i_clk9m_pcen(i_clk9m_pcen),
        .i_vblank_n(i_vblank_n), .i_frame_parity(i_frame_parity),
        .i_ack_vblank_n(ack_vblank_n), .i_ack_fparity_n(ack_fparity_n),
        .i_ack_timer_n(ack_timer_n), .o_ipl_n(o_ipl_n)
    );

    bubsys_cfg_latch u_cfg (
        .mclk(mclk), .maincpu_rst(maincpu_rst),
        .i_syscfg_cs(syscfg_cs), .i_sndlatch_cs(sndlatch_cs),
        .i_addr(i_addr), .i_data(i_data), .i_r_nw(i_r_nw),
        .i_uds_n(i_uds_n), .i_lds_n(i_lds_n),
        .o_snd_int(o_snd_int), .o_snd_nmi(o_snd_nmi),
        .o_ack_timer_n(ack_timer_n), .o_ack_vblank_n(ack_vblank_n),
        .o_ack_fparity_n(ack_fparity_n),
        .o_hflip(o_hflip), .o_vflip(o_vflip), .o_snd_code(o_snd_code)
    );

    bubsys_palette u_palette (
        .mclk(mclk), .i_clk6m_pcen(i_clk6m_pcen), .i_palram_cs(palram_cs),
        .i_addr(i_addr), .i_data(i_data), .i_r_nw(i_r_nw),
        .i_uds_n(i_uds_n), .i_lds_n(i_lds_n), .i_cd(i_cd), .i_blk(i_blk),
        .o_q(palram_q), .o_video_r(o_video_r), .o_video_g(o_video_g),
        .o_video_b(o_video_b)
    );

    ////////////////////////////////////////////////////////////
    // read data mux

    assign gfx_cs = ~&{o_vzcs_n, o_vcs1_n, o_vcs2_n, o_chacs_n, o_objram_n};

    always_comb begin
        o_data = OPEN_BUS;
        if (workram_cs) o_data = workram_q;
        else if (palram_cs) o_data = palram_q;
        else if (gfx_cs) o_data = i_gfx_do;
        else if (btn_cs) begin
            case (i_addr[2:1])
                2'd0:    o_data = {8'hFF, i_in0};
                2'd1:    o_data = {8'hFF, i_in1};
                2'd2:    o_data = {8'hFF, i_in2};
                default: o_data = OPEN_BUS;
            endcase
        end else if (dip_cs) begin
            case (i_addr[2:1])
                2'd1:    o_data = {8'hFF, i_dipsw1};
                2'd2:    o_data = {8'hFF, i_dipsw2};
                2'd3:    o_data = {8'hFF, i_dipsw3};
                default: o_data = OPEN_BUS;     // offset 0 not fitted
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/bubsys_palette.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubsys_palette
    import bubsys_pkg::*;
(
    input  logic      mclk,
    input  logic      i_clk6m_pcen,
    input  logic      i_palram_cs,
    input  cpu_addr_t i_addr,
    input  cpu_data_t i_data,
    input  logic      i_r_nw,
    input  logic      i_uds_n,
    input  logic      i_lds_n,
    input  pal_addr_t i_cd,
    input  logic      i_blk,
    output cpu_data_t o_q,
    output color_t    o_video_r,
    output color_t    o_video_g,
    output color_t    o_video_b
);

    byte_t       pal_hi [0:2047];
    byte_t       pal_lo [0:2047];
    pal_addr_t   pal_addr;
    logic [14:0] rgb_latch;

    // cpu takes the ram while selected, video lookup otherwise
    assign pal_addr = i_palram_cs ? i_addr[11:1] : i_cd;

    always_ff @(posedge mclk) begin
        if (i_palram_cs && !i_r_nw) begin
            if (!i_uds_n) pal_hi[pal_addr] <= i_data[15:8];
            if (!i_lds_n) pal_lo[pal_addr] <= i_data[7:0];
        end
        o_q <= {pal_hi[pal_addr], pal_lo[pal_addr]};
    end

    ////////////////////////////////////////////////////////////
    // rgb output latch

    always_ff @(posedge mclk) begin
        if (i_clk6m_pcen) rgb_latch <= o_q[14:0];   // bit 15 unused
    end

    assign o_video_r = i_blk ? rgb_latch[4:0]   : 5'd0;
    assign o_video_g = i_blk ? rgb_latch[9:5]   : 5'd0;
    assign o_video_b = i_blk ? rgb_latch[14:10] : 5'd0;

endmodule

`default_nettype wire

// ==== hw/bubsys_pkg.sv ====
`default_nettype none

package bubsys_pkg;

    ////////////////////////////////////////////////////////////
    // bus and video widths
    typedef logic [23:1] cpu_addr_t;    // 68000 word address
    typedef logic [15:0] cpu_data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  color_t;
    typedef logic [10:0] pal_addr_t;
    typedef logic [2:0]  ipl_t;         // active low level code

    typedef enum logic [2:0] {
        IDLE,
        RF1,
        RF2,
        RF3,
        PENDING     // refresh due, cpu still on work ram
    } rfsh_state_t;

    ////////////////////////////////////////////////////////////
    // address map
    // first decoder, addr[18:16]
    localparam logic [2:0] PAGE_BOOT   = 3'b000;
    localparam logic [2:0] PAGE_WORK   = 3'b001;
    localparam logic [2:0] PAGE_SNDRAM = 3'b010;
    localparam logic [2:0] PAGE_CHAR   = 3'b011;
    localparam logic [2:0] PAGE_VIDEO  = 3'b101;
    localparam logic [2:0] PAGE_EXT    = 3'b111;

    // second decoder, addr[15:13] in the video page
    localparam logic [2:0] SUB_VZ  = 3'b000;
    localparam logic [2:0] SUB_V1  = 3'b001;
    localparam logic [2:0] SUB_V2  = 3'b010;
    localparam logic [2:0] SUB_OBJ = 3'b011;
    localparam logic [2:0] SUB_PAL = 3'b101;
    localparam logic [2:0] SUB_SYS = 3'b110;   // io block
    localparam logic [2:0] SUB_CFG = 3'b111;   // output bit latch

    // third decoder, addr[12:10] in the io block
    localparam logic [2:0] IO_SNDLATCH = 3'b000;
    localparam logic [2:0] IO_DIP      = 3'b001;
    localparam logic [2:0] IO_BTN      = 3'b011;

    ////////////////////////////////////////////////////////////
    // interrupt levels, read bus
    localparam ipl_t IPL_TIMER   = 3'b011;
    localparam ipl_t IPL_VBLANK  = 3'b101;
    localparam ipl_t IPL_FPARITY = 3'b110;
    localparam ipl_t IPL_NONE    = 3'b111;

    localparam cpu_data_t OPEN_BUS = 16'hFFFF;

endpackage

`default_nettype wire

// ==== hw/bubsys_work_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubsys_work_ram
    import bubsys_pkg::*;
(
    input  logic        mclk,
    input  logic        maincpu_rst,
    input  logic        i_clk6m_pcen,
    input  logic        i_abs_32h,
    input  logic        i_workram_cs,
    input  cpu_addr_t   i_addr,
    input  cpu_data_t   i_data,
    input  logic        i_r_nw,
    input  logic        i_uds_n,
    input  logic        i_lds_n,
    output cpu_data_t   o_q,
    output logic        o_wram_ready
);

    ////////////////////////////////////////////////////////////
    // storage, 2 x 32K x 8

    byte_t ram_hi [0:32767];
    byte_t ram_lo [0:32767];

    always_ff @(posedge mclk) begin
        if (i_workram_cs && !i_r_nw) begin
            if (!i_uds_n) ram_hi[i_addr[15:1]] <= i_data[15:8];
            if (!i_lds_n) ram_lo[i_addr[15:1]] <= i_data[7:0];
        end
        o_q <= {ram_hi[i_addr[15:1]], ram_lo[i_addr[15:1]]};
    end

    ////////////////////////////////////////////////////////////
    // refresh scheduler

    rfsh_state_t rfsh_state;
    logic        abs_32h_z;
    logic        abs_32h_pe;

    assign abs_32h_pe = i_abs_32h & ~abs_32h_z;

    always_ff @(posedge mclk) begin
        if (maincpu_rst) begin
            abs_32h_z  <= 1'b0;
            rfsh_state <= IDLE;
        end else if (i_clk6m_pcen) begin
            abs_32h_z <= i_abs_32h;
            case (rfsh_state)
                IDLE:    if (abs_32h_pe) rfsh_state <= i_workram_cs ? PENDING : RF1;
                PENDING: if (!i_workram_cs) rfsh_state <= RF1;   // wait for cpu to leave
                RF1:     rfsh_state <= RF2;
                RF2:     rfsh_state <= RF3;
                RF3:     rfsh_state <= IDLE;
                default: rfsh_state <= IDLE;
            endcase
        end
    end

    // cpu only stalls while a refresh is actually running
    assign o_wram_ready = i_workram_cs & ((rfsh_state == IDLE) | (rfsh_state == PENDING));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f bubsys.f --top-module tb_bubsys -o tb_bubsys_sim \
    && ./obj_dir/tb_bubsys_sim | tee /dev/stderr | grep -qx "sim passed" \
    && echo "simulation ok" \
    || { echo "simulation failed or did not build"; exit 1; }

// ==== tb/bubsys_input.txt ====
// test_op_byteaddr_data_mask_expected, ops 0 wr 1 rd 2 set 3 vbl 4 par 5 check
// mask bit1 uds, bit0 lds, bit2 start inside a refresh; ff ends the list
01_00_010100_abcd_3_0000
01_00_010100_0012_1_0000
01_01_010100_0000_3_ab12
01_00_010200_5678_7_0000
01_00_010200_0099_5_0000
01_01_010200_0000_7_5699
02_00_05a00a_1234_3_0000
02_02_000006_0005_0_0000
02_02_000007_0001_0_0000
02_05_000006_0000_0_1234
02_02_000007_0000_0_0000
02_05_000006_0000_0_0000
03_02_000000_005a_0_0000
03_01_05cc00_0000_3_ff5a
03_02_000002_003c_0_0000
03_01_05cc04_0000_3_ff3c
03_01_05cc06_0000_3_ffff
03_02_000003_0081_0_0000
03_01_05c402_0000_3_ff81
03_02_000005_007e_0_0000
03_01_05c406_0000_3_ff7e
03_01_05c400_0000_3_ffff
03_01_040000_0000_3_ffff
04_00_05c000_00a5_1_0000
04_05_000001_0000_0_00a5
04_00_05c000_3300_2_0000
04_05_000001_0000_0_00a5
04_00_05e004_0001_1_0000
04_05_000002_0000_0_0001
04_00_05e006_0001_1_0000
04_05_000003_0000_0_0001
04_00_05e004_0000_1_0000
04_05_000002_0000_0_0000
04_00_05e004_0100_2_0000
04_05_000004_0000_0_0001
04_00_05e008_0100_2_0000
04_05_000005_0000_0_0001
04_00_05e004_0000_2_0000
04_05_000004_0000_0_0000
05_00_05e000_0001_1_0000
05_00_05e002_0001_1_0000
05_00_05e00e_0100_2_0000
05_03_000000_0000_0_0000
05_05_000000_0000_0_0003
05_00_05e00e_0000_2_0000
05_00_05e00e_0100_2_0000
05_05_000000_0000_0_0005
05_00_05e000_0000_1_0000
05_00_05e000_0001_1_0000
05_05_000000_0000_0_0007
05_04_000000_0000_0_0000
05_05_000000_0000_0_0006
06_02_000008_beef_0_0000
06_01_052000_0000_3_beef
06_05_000007_0000_0_0017
06_01_056000_0000_3_beef
06_05_000007_0000_0_001d
06_01_050000_0000_3_beef
06_05_000007_0000_0_000f
ff_00_000000_0000_0_0000

// ==== tb/tb_bubsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bubsys
    import bubsys_pkg::*;
;

    logic        mclk, maincpu_rst;
    logic        i_clk6m_pcen, i_clk6m_ncen, i_clk9m_pcen;
    logic        i_vblank_n, i_frame_parity, i_blk;
    pal_addr_t   i_cd;
    cpu_addr_t   i_addr;
    logic        i_as_n, i_uds_n, i_lds_n, i_r_nw;
    cpu_data_t   i_data, o_data, i_gfx_do, o_gfx_di;
    logic        o_dtack_n;
    ipl_t        o_ipl_n;
    logic [14:0] o_gfx_addr;
    logic        o_gfx_r_nw, o_gfx_uds_n, o_gfx_lds_n;
    logic        o_vzcs_n, o_vcs1_n, o_vcs2_n, o_chacs_n, o_objram_n, o_sndram_cs;
    logic        o_hflip, o_vflip, o_snd_int, o_snd_nmi;
    byte_t       o_snd_code, i_in0, i_in1, i_in2, i_dipsw1, i_dipsw2, i_dipsw3;
    color_t      o_video_r, o_video_g, o_video_b;

    logic [1:0]  div6, div9;
    logic [5:0]  hcnt;             // 1h, 2h ... 32h
    logic [75:0] recs [0:127];
    logic [5:0]  gfx_sel;          // {snd, vz, v1, v2, obj, cha} at dtack
    int          nrec, errs, checks, test_errs;

    bubsys_main_bus dut0 (.*, .i_abs_1h_n(~hcnt[0]), .i_abs_2h(hcnt[1]), .i_abs_32h(hcnt[5]));

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;
    end

    // video enables and the h counter step on the falling edge
    always @(negedge mclk) begin
        if (i_clk6m_pcen) hcnt <= hcnt + 6'd1;
        div6         <= div6 + 2'd1;
        i_clk6m_pcen <= (div6 == 2'd3);
        i_clk6m_ncen <= (div6 == 2'd1);
        div9         <= (div9 == 2'd2) ? 2'd0 : div9 + 2'd1;
        i_clk9m_pcen <= (div9 == 2'd2);
    end

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errs++;
            test_errs++;
        end
    endtask

    // one 68000 cycle held until dtack
    task automatic bus_cycle(input logic [23:0] baddr, input logic rd, input cpu_data_t wdata,
                             input logic [1:0] lanes, output cpu_data_t rdata);
        int  n;
        logic got;
        n = 0;
        got = 1'b0;
        rdata = 16'hxxxx;
        i_addr  = baddr[23:1];
        i_r_nw  = rd;
        i_data  = wdata;
        i_as_n  = 1'b0;
        i_uds_n = ~lanes[1];
        i_lds_n = ~lanes[0];
        while (!got && n < 64) begin
            @(negedge mclk);
            n++;
            if (!o_dtack_n) got = 1'b1;
        end
        if (!got) begin
            $display("no DTACK within 64 mclk for bus cycle at address %h", baddr);
            errs++;
            test_errs++;
        end else begin
            gfx_sel = {o_sndram_cs, o_vzcs_n, o_vcs1_n, o_vcs2_n, o_objram_n, o_chacs_n};
            // graphics bus mirrors the cpu bus
            compare("o_gfx_addr", {1'b0, baddr[15:1]}, {1'b0, o_gfx_addr});
            compare("o_gfx_di", wdata, o_gfx_di);
            compare("o_gfx_r_nw", {15'd0, rd}, {15'd0, o_gfx_r_nw});
            compare("o_gfx_uds_n", {15'd0, ~lanes[1]}, {15'd0, o_gfx_uds_n});
            compare("o_gfx_lds_n", {15'd0, ~lanes[0]}, {15'd0, o_gfx_lds_n});
            if (rd) begin
                repeat (2) @(negedge mclk);    // registered ram data
                rdata = o_data;
            end
        end
        i_as_n  = 1'b1;
        i_uds_n = 1'b1;
        i_lds_n = 1'b1;
        i_r_nw  = 1'b1;
        repeat (2) @(negedge mclk);
        compare("o_dtack_n", 16'd1, {15'd0, o_dtack_n});
    endtask

    function automatic logic [15:0] port_value(input logic [3:0] sel);
        case (sel)
            4'd0:    return {13'd0, o_ipl_n};
            4'd1:    return {8'd0, o_snd_code};
            4'd2:    return {15'd0, o_hflip};
            4'd3:    return {15'd0, o_vflip};
            4'd4:    return {15'd0, o_snd_int};
            4'd5:    return {15'd0, o_snd_nmi};
            4'd6:    return {1'b0, o_video_b, o_video_g, o_video_r};
            default: return {10'd0, gfx_sel};
        endcase
    endfunction

    function automatic string port_name(input logic [3:0] sel);
        case (sel)
            4'd0:    return "o_ipl_n";
            4'd1:    return "o_snd_code";
            4'd2:    return "o_hflip";
            4'd3:    return "o_vflip";
            4'd4:    return "o_snd_int";
            4'd5:    return "o_snd_nmi";
            4'd6:    return "o_video_bgr";
            default: return "gfx_selects";
        endcase
    endfunction

    task automatic check_port(input logic [3:0] sel, input logic [15:0] exp);
        int n;
        for (n = 0; n < 8 && port_value(sel) !== exp; n++) @(negedge mclk);
        compare(port_name(sel), exp, port_value(sel));
    endtask

    task automatic set_input(input logic [3:0] sel, input logic [15:0] val);
        case (sel)
            4'd0:    i_in0 = val[7:0];
            4'd1:    i_in1 = val[7:0];
            4'd2:    i_in2 = val[7:0];
            4'd3:    i_dipsw1 = val[7:0];
            4'd4:    i_dipsw2 = val[7:0];
            4'd5:    i_dipsw3 = val[7:0];
            4'd6:    i_cd = val[10:0];
            4'd7:    i_blk = val[0];
            default: i_gfx_do = val;
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // watchdog allows 200 mclk per record
    initial begin
        wait (nrec > 0);
        repeat (200 * nrec) @(posedge mclk);
        $display("watchdog expired after %0d mclk, run did not finish", 200 * nrec);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [75:0] r;
        logic [7:0]  cur;
        cpu_data_t   rd;
        int          nfound;
        void'($urandom(29978));
        {div6, div9, hcnt} = '0;
        {i_clk6m_pcen, i_clk6m_ncen, i_clk9m_pcen} = 3'b000;
        {i_as_n, i_uds_n, i_lds_n, i_r_nw} = 4'hF;
        {i_vblank_n, i_frame_parity, i_blk} = 3'b100;
        i_addr = '0;
        i_data = '0;
        i_cd   = '0;
        {i_in0, i_in1, i_in2} = {8'($urandom), 8'($urandom), 8'($urandom)};
        {i_dipsw1, i_dipsw2, i_dipsw3} = {8'($urandom), 8'($urandom), 8'($urandom)};
        i_gfx_do = 16'($urandom);
        gfx_sel  = 6'h1F;
        {errs, checks, test_errs} = 0;
        for (int i = 0; i < 128; i++) recs[i] = '1;
        $readmemh("tb/bubsys_input.txt", recs);
        nfound = 0;
        while (nfound < 128 && recs[nfound][75:68] != 8'hFF) nfound++;
        nrec = nfound;
        maincpu_rst = 1'b1;
        repeat (10) @(negedge mclk);
        maincpu_rst = 1'b0;
        repeat (2) @(negedge mclk);
        cur = recs[0][75:68];
        for (int i = 0; i < nrec; i++) begin
            r = recs[i];
            if (r[75:68] != cur) begin
                $display("test %0d: %s", cur, (test_errs == 0) ? "ok" : "FAILED");
                cur = r[75:68];
                test_errs = 0;
            end
            if (r[18] && r[67:60] <= 8'd1) begin
                @(posedge hcnt[5]);            // land inside a refresh
                repeat (5) @(negedge mclk);
            end
            case (r[67:60])
                8'd0: bus_cycle(r[59:36], 1'b0, r[35:20], r[17:16], rd);
                8'd1: begin
                    bus_cycle(r[59:36], 1'b1, 16'h0000, r[17:16], rd);
                    compare("o_data", r[15:0], rd);
                end
                8'd2: set_input(r[39:36], r[35:20]);
                8'd3: begin
                    i_vblank_n = 1'b0;
                    repeat (4) @(negedge mclk);
                    i_vblank_n = 1'b1;
                end
                8'd4: begin
                    i_frame_parity = 1'b1;
                    repeat (4) @(negedge mclk);
                    i_frame_parity = 1'b0;
                end
                default: check_port(r[39:36], r[15:0]);
            endcase
        end
        $display("test %0d: %s", cur, (test_errs == 0) ? "ok" : "FAILED");
        $display("%0d records, %0d checks, %0d errors", nrec, checks, errs);
        if (errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
